/* common/core_pkg.sv */
package core_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,
        ALU_PASS_B = 3'd6
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    branch_ne;
        logic    jump;
        logic    link;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] pc;
        instr_u      instr;
        logic        valid;
    } if_id_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [31:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        ctrl_t       ctrl;
        logic        valid;
    } id_ex_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] alu_result;
        logic [31:0] rs2_data;
        logic [4:0]  rd;
        ctrl_t       ctrl;
        logic        valid;
    } ex_mem_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] alu_result;
        logic [31:0] mem_data;
        logic [4:0]  rd;
        ctrl_t       ctrl;
        logic        valid;
    } mem_wb_t;

endpackage

/* files.f */
+incdir+sim
common/core_pkg.sv
source/pipeline_registers.sv
source/decode_unit.sv
source/register_file.sv
source/execute_stage.sv
source/hazard_unit.sv
source/core_top.sv
sim/core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module core_tb \
    -f files.f \
    -o core_sim

./obj_dir/core_sim

/* sim/isa_model.svh */
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Architectural reference for the RV32I subset, one instruction per step
// Fills the expected retire queues and returns how many retires to expect
function automatic int run_model();
    logic [31:0] x [32];
    logic [31:0] mem [256];
    logic [31:0] pc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] val;
    logic [31:0] next_pc;
    logic [31:0] ea;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic        wr;
    logic        done;
    int          j;
    int          steps;
    exp_pc.delete();
    exp_rd.delete();
    exp_wdata.delete();
    for (j = 0; j < 32; j++) begin
        x[5'(j)] = 32'd0;
    end
    for (j = 0; j < 256; j++) begin
        mem[8'(j)] = fill_value(j);
    end
    pc = RESET_PC;
    done = 1'b0;
    steps = 0;
    while (!done && steps < 4096) begin
        w = imem[pc[9:2]];
        a = x[w[19:15]];
        b = x[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        wr = 1'b1;
        val = 32'd0;
        next_pc = pc + 32'd4;
        case (w[6:0])
            7'b0110011: begin
                case (w[14:12])
                    3'b000:  val = w[30] ? a - b : a + b;
                    3'b010:  val = {31'd0, $signed(a) < $signed(b)};
                    3'b100:  val = a ^ b;
                    3'b110:  val = a | b;
                    default: val = a & b;
                endcase
            end
            7'b0010011: val = a + imm_i;
            7'b0110111: val = {w[31:12], 12'd0};
            7'b0000011: begin
                ea = a + imm_i;
                val = mem[ea[9:2]];
            end
            7'b0100011: begin
                ea = a + imm_s;
                mem[ea[9:2]] = b;
                wr = 1'b0;
            end
            7'b1100011: begin
                wr = 1'b0;
                if ((a == b) != w[12])
                    next_pc = pc + imm_b;
            end
            7'b1101111: begin
                val = pc + 32'd4;
                next_pc = pc + imm_j;
                // A jump to itself ends the program
                done = (imm_j == 32'd0);
            end
            default: wr = 1'b0;
        endcase
        exp_pc.push_back(pc);
        if (wr && w[11:7] != 5'd0) begin
            x[w[11:7]] = val;
            exp_rd.push_back(w[11:7]);
            exp_wdata.push_back(val);
        end else begin
            exp_rd.push_back(5'd0);
            exp_wdata.push_back(32'd0);
        end
        pc = next_pc;
        steps = steps + 1;
    end
    return exp_pc.size();
endfunction

`endif

/* sim/core_tb.sv */
`timescale 1ns/1ps

module core_tb;

    localparam logic [31:0] RESET_PC = 32'h0000_0100;
    localparam int BASE = int'(RESET_PC[9:2]);
    localparam int PROG_LEN = 40;
    localparam int NUM_PROGS = 8;

    logic        clk;
    logic        reset;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic [31:0] dmem_rdata;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic [31:0] retire_wdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_wdata [$];
    int          n_exp;
    int          idx;
    integer      seed;

    core_top #(.RESET_PC(RESET_PC)) core_i (
        .clk(clk),
        .reset(reset),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata),
        .dmem_we(dmem_we),
        .dmem_rdata(dmem_rdata),
        .retire_valid(retire_valid),
        .retire_pc(retire_pc),
        .retire_rd(retire_rd),
        .retire_wdata(retire_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] fill_value(int j);
        return j * 7 + 3;
    endfunction

    `include "isa_model.svh"

    // Both memory models read combinationally
    assign imem_data = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    // Data memory comes back to its fill pattern on every reset
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int j = 0; j < 256; j++) begin
                dmem[8'(j)] <= fill_value(j);
            end
        end else if (dmem_we) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL at %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    // x0 to x7 only, so dependencies come often
    function automatic logic [4:0] rand_reg();
        logic [31:0] r;
        r = rand_word();
        return {2'b00, r[2:0]};
    endfunction

    function automatic int rand_below(int n);
        logic [31:0] r;
        r = rand_word();
        return int'(r % n);
    endfunction

    function automatic logic [31:0] encode_r(int op, logic [4:0] rd, logic [4:0] rs1,
                                             logic [4:0] rs2);
        logic [2:0] f3;
        logic [6:0] f7;
        f7 = 7'd0;
        case (op)
            0:       f3 = 3'b000;
            1: begin
                f3 = 3'b000;
                f7 = 7'b0100000;
            end
            2:       f3 = 3'b111;
            3:       f3 = 3'b110;
            4:       f3 = 3'b100;
            default: f3 = 3'b010;
        endcase
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    // kind 0 ALU only, 1 adds memory, 2 adds control flow, 3 everything
    task automatic gen_program(input int kind);
        int          i;
        int          j;
        int          sel;
        int          k;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] r;
        logic [11:0] off;
        logic [12:0] boff;
        logic [20:0] joff;
        for (j = 0; j < 256; j++) begin
            imem[8'(j)] = 32'd0;
        end
        i = 0;
        while (i < PROG_LEN - 1) begin
            sel = rand_below(kind == 0 ? 8 : (kind == 3 ? 12 : 10));
            if (kind == 2 && sel >= 8)
                sel = sel + 2;
            if ((sel == 8 || sel == 9) && i + 2 > PROG_LEN - 1)
                sel = 6;
            rd = rand_reg();
            rs1 = rand_reg();
            rs2 = rand_reg();
            r = rand_word();
            off = {2'b00, r[7:0], 2'b00};
            k = 1 + rand_below(3);
            if (i + k > PROG_LEN - 1)
                k = PROG_LEN - 1 - i;
            boff = 13'(k * 4);
            joff = 21'(k * 4);
            case (sel)
                6: imem[8'(BASE + i)] = {r[31:20], rs1, 3'b000, rd, 7'b0010011};
                7: imem[8'(BASE + i)] = {r[31:12], rd, 7'b0110111};
                8: begin
                    // Load, then use it at once
                    imem[8'(BASE + i)] = {off, 5'd0, 3'b010, rd, 7'b0000011};
                    imem[8'(BASE + i + 1)] = encode_r(0, rs2, rd, rs1);
                end
                9: begin
                    imem[8'(BASE + i)] = {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'b0100011};
                    imem[8'(BASE + i + 1)] = {off, 5'd0, 3'b010, rd, 7'b0000011};
                end
                10: imem[8'(BASE + i)] = {boff[12], boff[10:5], rs2, rs1, 2'b00, r[0],
                                          boff[4:1], boff[11], 7'b1100011};
                11: imem[8'(BASE + i)] = {joff[20], joff[10:1], joff[11], joff[19:12],
                                          rd, 7'b1101111};
                default: imem[8'(BASE + i)] = encode_r(sel, rd, rs1, rs2);
            endcase
            i = i + ((sel == 8 || sel == 9) ? 2 : 1);
        end
        imem[8'(BASE + PROG_LEN - 1)] = {20'd0, 5'd0, 7'b1101111};
    endtask

    task automatic release_reset();
        repeat (8) @(posedge clk);
        check_value({30'd0, retire_valid, dmem_we}, 32'd0, "retire_valid/dmem_we in reset");
        check_value(imem_addr, RESET_PC, "fetch address in reset");
        reset <= 1'b0;
    endtask

    task automatic wait_for_retires(input int count);
        int cycles;
        int limit;
        cycles = 0;
        limit = 5 * n_exp + 50;
        while (idx < count) begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles > limit) begin
                $display("Timeout at %0t: core stopped retiring after %0d of %0d instructions",
                         $time, idx, count);
                $display("ERRORS FOUND");
                $fatal(1, "timeout");
            end
        end
    endtask

    // Retires compared in order, away from the clock edge
    always @(negedge clk) begin
        if (reset) begin
            idx <= 0;
        end else if (retire_valid && idx < n_exp) begin
            check_value(retire_pc, exp_pc[idx], "retire_pc");
            check_value({27'd0, retire_rd}, {27'd0, exp_rd[idx]}, "retire_rd");
            check_value(retire_wdata, exp_wdata[idx], "retire_wdata");
            idx <= idx + 1;
        end
    end

    initial begin
        seed = 12;
        reset = 1'b1;
        n_exp = 0;
        for (int prog = 0; prog < NUM_PROGS; prog++) begin
            if (prog > 0) begin
                @(posedge clk);
                reset <= 1'b1;
            end
            gen_program(prog % 4);
            n_exp = run_model();
            release_reset();
            if (prog == NUM_PROGS - 1) begin
                // Halfway restart begins the stream again at RESET_PC
                wait_for_retires(n_exp / 2);
                @(posedge clk);
                reset <= 1'b1;
                release_reset();
            end
            wait_for_retires(n_exp);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* source/core_top.sv */
`timescale 1ns/1ps

module core_top #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] imem_addr,
    input  logic [31:0] imem_data,
    output logic [31:0] dmem_addr,
    output logic [31:0] dmem_wdata,
    output logic        dmem_we,
    input  logic [31:0] dmem_rdata,
    output logic        retire_valid,
    output logic [31:0] retire_pc,
    output logic [4:0]  retire_rd,
    output logic [31:0] retire_wdata
);
    import core_pkg::*;

    logic [31:0] pc;
    logic        flush;
    logic        if_id_hold;
    logic        id_ex_bubble;
    logic        redirect;
    logic [31:0] redirect_pc;

    if_id_t  if_in;
    id_ex_t  id_ex_in;
    ex_mem_t ex_mem_in;
    mem_wb_t mem_wb_in;
    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;

    ctrl_t       id_ctrl;
    logic [4:0]  id_rd;
    logic [4:0]  id_rs1;
    logic [4:0]  id_rs2;
    logic [31:0] id_imm;
    logic        id_legal;
    logic        id_valid;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;

    logic        wb_we;
    logic [31:0] wb_value;

    // Redirect wins over a load-use hold
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!if_id_hold) begin
            pc <= pc + 32'd4;
        end
    end

    assign imem_addr = pc;

    always_comb begin
        if_in.pc = pc;
        if_in.instr = imem_data;
        if_in.valid = 1'b1;
    end

    pipeline_registers u_pipe (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .if_id_hold(if_id_hold),
        .id_ex_bubble(id_ex_bubble),
        .if_in(if_in),
        .id_ex_in(id_ex_in),
        .ex_mem_in(ex_mem_in),
        .mem_wb_in(mem_wb_in),
        .if_id(if_id),
        .id_ex(id_ex),
        .ex_mem(ex_mem),
        .mem_wb(mem_wb)
    );

    decode_unit u_decode (
        .instr(if_id.instr),
        .valid(if_id.valid),
        .ctrl(id_ctrl),
        .rd(id_rd),
        .rs1(id_rs1),
        .rs2(id_rs2),
        .imm(id_imm),
        .legal(id_legal)
    );

    // Undefined opcodes continue as bubbles
    assign id_valid = if_id.valid && id_legal;

    register_file u_regs (
        .clk(clk),
        .reset(reset),
        .rs1(id_rs1),
        .rs2(id_rs2),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .we(wb_we),
        .rd(mem_wb.rd),
        .wdata(wb_value)
    );

    always_comb begin
        id_ex_in.pc = if_id.pc;
        id_ex_in.rs1_data = rs1_data;
        id_ex_in.rs2_data = rs2_data;
        id_ex_in.imm = id_imm;
        id_ex_in.rd = id_rd;
        id_ex_in.rs1 = id_rs1;
        id_ex_in.rs2 = id_rs2;
        id_ex_in.ctrl = id_ctrl;
        id_ex_in.valid = id_valid;
    end

    hazard_unit u_hazard (
        .id_rs1(id_rs1),
        .id_rs2(id_rs2),
        .id_valid(id_valid),
        .ex_ctrl(id_ex.ctrl),
        .ex_rd(id_ex.rd),
        .ex_valid(id_ex.valid),
        .redirect(redirect),
        .flush(flush),
        .if_id_hold(if_id_hold),
        .id_ex_bubble(id_ex_bubble)
    );

    execute_stage u_execute (
        .id_ex(id_ex),
        .ex_mem(ex_mem),
        .mem_wb(mem_wb),
        .wb_value(wb_value),
        .ex_out(ex_mem_in),
        .redirect(redirect),
        .redirect_pc(redirect_pc)
    );

    // Word-only data memory access
    assign dmem_addr = ex_mem.alu_result;
    assign dmem_wdata = ex_mem.rs2_data;
    assign dmem_we = ex_mem.valid && ex_mem.ctrl.mem_write;

    always_comb begin
        mem_wb_in.pc = ex_mem.pc;
        mem_wb_in.alu_result = ex_mem.alu_result;
        mem_wb_in.mem_data = dmem_rdata;
        mem_wb_in.rd = ex_mem.rd;
        mem_wb_in.ctrl = ex_mem.ctrl;
        mem_wb_in.valid = ex_mem.valid;
    end

    // JAL's link value already sits in alu_result
    assign wb_value = mem_wb.ctrl.mem_read ? mem_wb.mem_data : mem_wb.alu_result;
    assign wb_we = mem_wb.valid && mem_wb.ctrl.reg_write && mem_wb.rd != 5'd0;

    assign retire_valid = mem_wb.valid;
    assign retire_pc = mem_wb.pc;
    assign retire_rd = wb_we ? mem_wb.rd : 5'd0;
    assign retire_wdata = wb_we ? wb_value : 32'd0;

endmodule

/* source/decode_unit.sv */
`timescale 1ns/1ps

module decode_unit (
    input  core_pkg::instr_u instr,
    input  logic             valid,
    output core_pkg::ctrl_t  ctrl,
    output logic [4:0]       rd,
    output logic [4:0]       rs1,
    output logic [4:0]       rs2,
    output logic [31:0]      imm,
    output logic             legal
);
    import core_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcode_e'(instr.r_fmt.opcode);
    assign funct3 = instr.r_fmt.funct3;
    assign funct7 = instr.r_fmt.funct7;

    always_comb begin
        ctrl = '0;
        imm = '0;
        legal = 1'b0;
        rd = instr.r_fmt.rd;
        rs1 = instr.r_fmt.rs1;
        rs2 = instr.r_fmt.rs2;
        case (opcode)
            OPC_OP: begin
                legal = 1'b1;
                ctrl.reg_write = 1'b1;
                case (funct3)
                    3'b000: ctrl.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b010: ctrl.alu_op = ALU_SLT;
                    3'b100: ctrl.alu_op = ALU_XOR;
                    3'b110: ctrl.alu_op = ALU_OR;
                    3'b111: ctrl.alu_op = ALU_AND;
                    default: legal = 1'b0;
                endcase
                // Only SUB may set funct7
                if (funct7 != 7'b0 && !(funct3 == 3'b000 && funct7 == 7'b0100000))
                    legal = 1'b0;
            end
            OPC_OP_IMM: begin
                legal = (funct3 == 3'b000);
                ctrl.alu_op = ALU_ADD;
                ctrl.use_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                rs2 = 5'd0;
                imm = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
            end
            OPC_LUI: begin
                legal = 1'b1;
                ctrl.alu_op = ALU_PASS_B;
                ctrl.use_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                rs1 = 5'd0;
                rs2 = 5'd0;
                // U immediate sits in the same upper 20 bits as the J fields
                imm = {instr.j_fmt.imm20, instr.j_fmt.imm10_1, instr.j_fmt.imm11,
                       instr.j_fmt.imm19_12, 12'b0};
            end
            OPC_LOAD: begin
                legal = (funct3 == 3'b010);
                ctrl.alu_op = ALU_ADD;
                ctrl.use_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.mem_read = 1'b1;
                rs2 = 5'd0;
                imm = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
            end
            OPC_STORE: begin
                legal = (funct3 == 3'b010);
                ctrl.alu_op = ALU_ADD;
                ctrl.use_imm = 1'b1;
                ctrl.mem_write = 1'b1;
                rd = 5'd0;
                imm = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
            end
            OPC_BRANCH: begin
                legal = (funct3 == 3'b000 || funct3 == 3'b001);
                ctrl.branch = 1'b1;
                ctrl.branch_ne = funct3[0];
                rd = 5'd0;
                imm = {{19{instr.b_fmt.imm12}}, instr.b_fmt.imm12, instr.b_fmt.imm11,
                       instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};
            end
            OPC_JAL: begin
                legal = 1'b1;
                ctrl.jump = 1'b1;
                ctrl.link = 1'b1;
                ctrl.reg_write = 1'b1;
                rs1 = 5'd0;
                rs2 = 5'd0;
                imm = {{11{instr.j_fmt.imm20}}, instr.j_fmt.imm20, instr.j_fmt.imm19_12,
                       instr.j_fmt.imm11, instr.j_fmt.imm10_1, 1'b0};
            end
            default: legal = 1'b0;
        endcase
        // Illegal or empty slots carry no control
        if (!legal || !valid) begin
            ctrl = '0;
        end
    end

endmodule

/* source/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  core_pkg::id_ex_t  id_ex,
    input  core_pkg::ex_mem_t ex_mem,
    input  core_pkg::mem_wb_t mem_wb,
    input  logic [31:0]       wb_value,
    output core_pkg::ex_mem_t ex_out,
    output logic              redirect,
    output logic [31:0]       redirect_pc
);
    import core_pkg::*;

    logic        ex_fwd;
    logic        wb_fwd;
    logic [31:0] op_a;
    logic [31:0] rs2_val;
    logic [31:0] op_b;
    logic [31:0] alu_result;
    logic        taken;

    // Load data is not ready in EX/MEM, the hazard unit stalls instead
    assign ex_fwd = ex_mem.valid && ex_mem.ctrl.reg_write && !ex_mem.ctrl.mem_read
                    && ex_mem.rd != 5'd0;
    assign wb_fwd = mem_wb.valid && mem_wb.ctrl.reg_write && mem_wb.rd != 5'd0;

    always_comb begin
        if (ex_fwd && ex_mem.rd == id_ex.rs1)
            op_a = ex_mem.alu_result;
        else if (wb_fwd && mem_wb.rd == id_ex.rs1)
            op_a = wb_value;
        else
            op_a = id_ex.rs1_data;

        if (ex_fwd && ex_mem.rd == id_ex.rs2)
            rs2_val = ex_mem.alu_result;
        else if (wb_fwd && mem_wb.rd == id_ex.rs2)
            rs2_val = wb_value;
        else
            rs2_val = id_ex.rs2_data;
    end

    assign op_b = id_ex.ctrl.use_imm ? id_ex.imm : rs2_val;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_ADD:    alu_result = op_a + op_b;
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_OR:     alu_result = op_a | op_b;
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SLT:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

    // Branch compare on the forwarded register values
    assign taken = id_ex.ctrl.jump
                   || (id_ex.ctrl.branch && ((op_a == rs2_val) != id_ex.ctrl.branch_ne));
    assign redirect = id_ex.valid && taken;
    assign redirect_pc = id_ex.pc + id_ex.imm;

    always_comb begin
        ex_out.pc = id_ex.pc;
        ex_out.alu_result = id_ex.ctrl.link ? id_ex.pc + 32'd4 : alu_result;
        ex_out.rs2_data = rs2_val;
        ex_out.rd = id_ex.rd;
        ex_out.ctrl = id_ex.ctrl;
        ex_out.valid = id_ex.valid;
    end

endmodule

/* source/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
    input  logic            [4:0] id_rs1,
    input  logic            [4:0] id_rs2,
    input  logic                  id_valid,
    input  core_pkg::ctrl_t       ex_ctrl,
    input  logic            [4:0] ex_rd,
    input  logic                  ex_valid,
    input  logic                  redirect,
    output logic                  flush,
    output logic                  if_id_hold,
    output logic                  id_ex_bubble
);

    logic load_use;

    // Unused sources arrive as x0, so they never match
    assign load_use = ex_valid && ex_ctrl.mem_read && ex_rd != 5'd0 && id_valid
                      && (ex_rd == id_rs1 || ex_rd == id_rs2);

    // A taken transfer discards the dependent instruction anyway
    assign flush = redirect;
    assign if_id_hold = load_use && !redirect;
    assign id_ex_bubble = load_use && !redirect;

endmodule

/* source/pipeline_registers.sv */
`timescale 1ns/1ps

module pipeline_registers (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  logic              if_id_hold,
    input  logic              id_ex_bubble,
    input  core_pkg::if_id_t  if_in,
    input  core_pkg::id_ex_t  id_ex_in,
    input  core_pkg::ex_mem_t ex_mem_in,
    input  core_pkg::mem_wb_t mem_wb_in,
    output core_pkg::if_id_t  if_id,
    output core_pkg::id_ex_t  id_ex,
    output core_pkg::ex_mem_t ex_mem,
    output core_pkg::mem_wb_t mem_wb
);

    // IF/ID
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            if_id <= '0;
        end else if (flush) begin
            if_id <= '0;
        end else if (!if_id_hold) begin
            if_id <= if_in;
        end
    end

    // ID/EX bubble is an all-zero entry
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_ex <= '0;
        end else if (flush || id_ex_bubble) begin
            id_ex <= '0;
        end else begin
            id_ex <= id_ex_in;
        end
    end

    // EX/MEM and MEM/WB never stall
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= ex_mem_in;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_wb <= '0;
        end else begin
            mem_wb <= mem_wb_in;
        end
    end

    // A held IF/ID entry must always leave a gap behind it in ID/EX
    hold_with_bubble: assert property (
        @(posedge clk) disable iff (reset) if_id_hold == id_ex_bubble
    ) else $error("IF/ID hold and ID/EX bubble out of step");

endmodule

/* source/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    input  logic        we,
    input  logic [4:0]  rd,
    input  logic [31:0] wdata
);

    // x0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // Same-cycle write shows through to the readers
    always_comb begin
        if (rs1 == 5'd0)
            rs1_data = '0;
        else if (we && rd == rs1)
            rs1_data = wdata;
        else
            rs1_data = regs[rs1];

        if (rs2 == 5'd0)
            rs2_data = '0;
        else if (we && rd == rs2)
            rs2_data = wdata;
        else
            rs2_data = regs[rs2];
    end

    // Writeback filters x0 before it gets here
    no_x0_write: assert property (
        @(posedge clk) disable iff (reset) we |-> rd != 5'd0
    ) else $error("write request for x0 reached the register file");

endmodule
